// File: filelist.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_stream_fifo.sv
rtl/dma_engine_regs.sv
rtl/dma_global_ctrl.sv
rtl/dma_wr_requester.sv
rtl/dma_logic.sv
tests/dma_logic_tb.sv

// File: rtl/dma_consts.svh
/* Build-time constants of the DMA write path.
   Payload and beat sizes must be powers of two, and the payload at least one beat */
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Stream geometry
`define DMA_BUS_WIDTH        64
`define DMA_BEAT_BYTES       8
`define DMA_LOG2_MAX_PAYLOAD 7   // 128 bytes, 16 beats per request
`define DMA_FIFO_DEPTH       16

////////////////////////////////////////
// Register map
////////////////////////////////////////
`define DMA_ADDR_WIDTH  16
`define DMA_ENGINE_BASE 'h200
`define DMA_REG_CTRL    0
`define DMA_REG_ADDR    8
`define DMA_REG_SIZE    16
`define DMA_GLOBAL_REG  'h2200  // Engine base plus one engine spacing of 'h2000

`endif

// File: rtl/dma_engine_regs.sv
/* Descriptor and control registers of the single engine.
   Read data is registered and valid with the ack, one cycle after EN.
   Start is combinational so the requester loads at the same edge as the write */
`timescale 1ns/1ps
`default_nettype none
`include "dma_consts.svh"

module dma_engine_regs (
	input  wire                   CLK,
	input  wire                   eng_reset_n,
	input  wire dma_pkg::reg_req_t bus_req,
	output logic [63:0]           rdata,
	output dma_pkg::engine_desc_t desc,
	input  wire                   done,
	input  wire                   busy,
	output logic                  irq_pending
);

	localparam logic [`DMA_ADDR_WIDTH-1:0] CTRL_ADDR =
		`DMA_ADDR_WIDTH'(`DMA_ENGINE_BASE + `DMA_REG_CTRL);
	localparam logic [`DMA_ADDR_WIDTH-1:0] ADDR_ADDR =
		`DMA_ADDR_WIDTH'(`DMA_ENGINE_BASE + `DMA_REG_ADDR);
	localparam logic [`DMA_ADDR_WIDTH-1:0] SIZE_ADDR =
		`DMA_ADDR_WIDTH'(`DMA_ENGINE_BASE + `DMA_REG_SIZE);

	logic [63:0] addr_r;
	logic [63:0] size_r;
	logic        enable_r;
	logic        stopped_r;
	logic        pending_r;
	logic        wr;
	logic        start;
	logic [7:0]  ctrl_byte;

	// Byte-lane merge of a 64-bit register write
	function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] wdata,
		input logic [7:0] we);
		logic [63:0] res;
		res = old;
		for (int i = 0; i < 8; i++) begin
			if (we[i]) res[i*8 +: 8] = wdata[i*8 +: 8];
		end
		return res;
	endfunction

	assign wr        = bus_req.en & (|bus_req.we);
	assign ctrl_byte = {pending_r, 3'b000, stopped_r, 2'b00, enable_r};

	// Enable write with a nonzero beat-aligned size while idle
	assign start = wr && (bus_req.addr == CTRL_ADDR) && bus_req.we[0] && bus_req.wdata[0]
		&& (size_r >= 64'(`DMA_BEAT_BYTES)) && !busy;

	assign desc        = '{start: start, addr: addr_r, size: size_r};
	assign irq_pending = pending_r;

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!eng_reset_n) begin
			addr_r    <= '0;
			size_r    <= '0;
			enable_r  <= 1'b0;
			stopped_r <= 1'b0;
			pending_r <= 1'b0;
		end else begin
			if (wr && bus_req.addr == ADDR_ADDR) addr_r <= merge(addr_r, bus_req.wdata, bus_req.we);
			if (wr && bus_req.addr == SIZE_ADDR) size_r <= merge(size_r, bus_req.wdata, bus_req.we);
			if (wr && bus_req.addr == CTRL_ADDR && bus_req.we[0]) begin
				enable_r <= bus_req.wdata[0];
				if (bus_req.wdata[7]) pending_r <= 1'b0;   // Write 1 to clear
			end
			if (start) stopped_r <= 1'b0;
			if (done) begin   // Completion wins over a clear in the same cycle
				stopped_r <= 1'b1;
				pending_r <= 1'b1;
			end
		end
	end

	// Readback, zero for addresses outside the engine
	always_ff @(posedge CLK) begin
		if (bus_req.en) begin
			case (bus_req.addr)
				CTRL_ADDR: rdata <= {56'b0, ctrl_byte};
				ADDR_ADDR: rdata <= addr_r;
				SIZE_ADDR: rdata <= size_r;
				default:   rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/dma_global_ctrl.sv
/* Global register, soft reset and bus response merge.
   The soft reset lasts one cycle and leaves the interrupt enable alone */
`timescale 1ns/1ps
`default_nettype none
`include "dma_consts.svh"

module dma_global_ctrl (
	input  wire                    CLK,
	input  wire                    dma_reset_n,
	input  wire dma_pkg::reg_req_t bus_req,
	input  wire [63:0]             eng_rdata,
	output dma_pkg::reg_rsp_t      bus_rsp,
	input  wire                    irq_pending,
	output logic                   irq,
	output logic                   eng_reset_n
);

	localparam logic [`DMA_ADDR_WIDTH-1:0] GLOBAL_ADDR = `DMA_ADDR_WIDTH'(`DMA_GLOBAL_REG);
	localparam logic [2:0] PAYLOAD_CODE = 3'(`DMA_LOG2_MAX_PAYLOAD - 7);

	logic ack_r;
	logic hit_r;      // Last access targeted the global register
	logic irq_en_r;
	logic soft_rst_r;
	logic global_wr;

	assign global_wr = bus_req.en && bus_req.we[0] && (bus_req.addr == GLOBAL_ADDR);

	always_ff @(posedge CLK) begin
		if (!dma_reset_n) begin
			ack_r      <= 1'b0;
			hit_r      <= 1'b0;
			irq_en_r   <= 1'b0;
			soft_rst_r <= 1'b0;
		end else begin
			ack_r      <= bus_req.en;   // Every address is acknowledged
			hit_r      <= bus_req.en && (bus_req.addr == GLOBAL_ADDR);
			soft_rst_r <= global_wr & bus_req.wdata[7];
			if (global_wr) irq_en_r <= bus_req.wdata[6];
		end
	end

	// Soft reset bit always reads 0
	assign bus_rsp = '{ack: ack_r,
		rdata: hit_r ? {56'b0, 1'b0, irq_en_r, 3'b000, PAYLOAD_CODE} : eng_rdata};

	assign irq         = irq_pending & irq_en_r;
	assign eng_reset_n = dma_reset_n & ~soft_rst_r;

endmodule

`default_nettype wire

// File: rtl/dma_logic.sv
/* Top of the single-engine C2S write path.
   C2S keep is not carried, every beat is taken as full */
`timescale 1ns/1ps
`default_nettype none

module dma_logic (
	input  wire                        CLK,
	input  wire                        dma_reset_n,
	// CPU register bus
	input  wire dma_pkg::reg_req_t     bus_req,
	output wire dma_pkg::reg_rsp_t     bus_rsp,
	// User stream in
	input  wire                        c2s_valid,
	output wire                        c2s_ready,
	input  wire dma_pkg::stream_beat_t c2s_data,
	// Requester stream out
	output wire                        rq_valid,
	input  wire                        rq_ready,
	output wire dma_pkg::stream_beat_t rq_beat,
	output wire dma_pkg::rq_hdr_t      rq_hdr,
	output wire                        irq,
	output wire                        operation_in_course
);

	wire                        eng_reset_n;
	wire                        fifo_valid;
	wire                        fifo_ready;
	wire dma_pkg::stream_beat_t fifo_data;
	wire dma_pkg::engine_desc_t desc;
	wire                        done;
	wire [63:0]                 eng_rdata;
	wire                        irq_pending;

	dma_global_ctrl dma_global_ctrl_inst (
		.CLK         (CLK),
		.dma_reset_n (dma_reset_n),
		.bus_req     (bus_req),
		.eng_rdata   (eng_rdata),
		.bus_rsp     (bus_rsp),
		.irq_pending (irq_pending),
		.irq         (irq),
		.eng_reset_n (eng_reset_n)
	);

	dma_engine_regs dma_engine_regs_inst (
		.CLK         (CLK),
		.eng_reset_n (eng_reset_n),
		.bus_req     (bus_req),
		.rdata       (eng_rdata),
		.desc        (desc),
		.done        (done),
		.busy        (operation_in_course),
		.irq_pending (irq_pending)
	);

	dma_stream_fifo c2s_fifo_inst (
		.CLK         (CLK),
		.eng_reset_n (eng_reset_n),
		.in_valid    (c2s_valid),
		.in_ready    (c2s_ready),
		.in_data     (c2s_data),
		.out_valid   (fifo_valid),
		.out_ready   (fifo_ready),
		.out_data    (fifo_data)
	);

	dma_wr_requester dma_wr_requester_inst (
		.CLK         (CLK),
		.eng_reset_n (eng_reset_n),
		.desc        (desc),
		.fifo_valid  (fifo_valid),
		.fifo_ready  (fifo_ready),
		.fifo_data   (fifo_data),
		.rq_valid    (rq_valid),
		.rq_ready    (rq_ready),
		.rq_beat     (rq_beat),
		.rq_hdr      (rq_hdr),
		.done        (done),
		.busy        (operation_in_course)
	);

endmodule

`default_nettype wire

// File: rtl/dma_pkg.sv
/* Shared types of the DMA write path.
   Widths follow the constants header */
`default_nettype none
`include "dma_consts.svh"

package dma_pkg;

	// One stream beat, used on C2S and on RQ
	typedef struct packed {
		logic [`DMA_BUS_WIDTH-1:0] data;
		logic                      last;
		logic                      sop;   // Only meaningful on RQ
	} stream_beat_t;

	// Memory write request header
	typedef struct packed {
		logic [63:0] addr;
		logic [10:0] dw_count;
	} rq_hdr_t;

	// CPU register bus, EN held for one cycle per access
	typedef struct packed {
		logic                       en;
		logic [`DMA_ADDR_WIDTH-1:0] addr;
		logic [63:0]                wdata;
		logic [7:0]                 we;
	} reg_req_t;

	typedef struct packed {
		logic        ack;
		logic [63:0] rdata;
	} reg_rsp_t;

	// Descriptor handed from the registers to the requester
	typedef struct packed {
		logic        start;   // Single-cycle pulse
		logic [63:0] addr;
		logic [63:0] size;
	} engine_desc_t;

endpackage

`default_nettype wire

// File: rtl/dma_stream_fifo.sv
/* Circular FIFO for the C2S user stream, one push and one pop per cycle.
   Output reads the storage directly, so a beat shows one cycle after its write */
`timescale 1ns/1ps
`default_nettype none
`include "dma_consts.svh"

module dma_stream_fifo (
	input  wire                        CLK,
	input  wire                        eng_reset_n,
	input  wire                        in_valid,
	output logic                       in_ready,
	input  wire dma_pkg::stream_beat_t in_data,
	output logic                       out_valid,
	input  wire                        out_ready,
	output dma_pkg::stream_beat_t      out_data
);

	localparam int unsigned DEPTH = `DMA_FIFO_DEPTH;
	localparam int unsigned PW    = $clog2(DEPTH);
	localparam int unsigned CW    = $clog2(DEPTH + 1);

	dma_pkg::stream_beat_t mem [DEPTH];
	logic [PW-1:0]         wr_ptr;
	logic [PW-1:0]         rd_ptr;
	logic [CW-1:0]         count;
	logic                  push;
	logic                  pop;

	assign in_ready  = (count != CW'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid & in_ready;
	assign pop       = out_valid & out_ready;

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!eng_reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Idle, or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/dma_wr_requester.sv
/* Splits one descriptor into memory write requests of at most the max payload.
   Size is taken in whole beats, the low bits are dropped.
   Data passes straight from the FIFO, so back-pressure holds the FIFO head */
`timescale 1ns/1ps
`default_nettype none
`include "dma_consts.svh"

module dma_wr_requester (
	input  wire                        CLK,
	input  wire                        eng_reset_n,
	input  wire dma_pkg::engine_desc_t desc,
	input  wire                        fifo_valid,
	output logic                       fifo_ready,
	input  wire dma_pkg::stream_beat_t fifo_data,
	output logic                       rq_valid,
	input  wire                        rq_ready,
	output dma_pkg::stream_beat_t      rq_beat,
	output dma_pkg::rq_hdr_t           rq_hdr,
	output logic                       done,
	output logic                       busy
);

	localparam int unsigned MAX_BYTES  = 1 << `DMA_LOG2_MAX_PAYLOAD;
	localparam int unsigned BEAT_SHIFT = $clog2(`DMA_BEAT_BYTES);
	localparam int unsigned MAX_BEATS  = MAX_BYTES / `DMA_BEAT_BYTES;
	localparam int unsigned BW         = $clog2(MAX_BEATS);

	logic          busy_r;
	logic [63:0]   addr_r;      // Address of the current request
	logic [63:0]   remain_r;    // Bytes left, current request included
	logic [BW-1:0] beat_cnt;
	logic [63:0]   req_bytes;
	logic [BW-1:0] last_beat;
	logic          accept;
	logic          beat_last;
	logic          final_req;

	////////////////////////////////////////
	// Current request geometry
	////////////////////////////////////////
	assign req_bytes = (remain_r > 64'(MAX_BYTES)) ? 64'(MAX_BYTES) : remain_r;
	assign last_beat = BW'((req_bytes >> BEAT_SHIFT) - 64'd1);
	assign final_req = (remain_r == req_bytes);
	assign beat_last = (beat_cnt == last_beat);

	// Stream handshake, a beat passes only while busy
	assign rq_valid   = busy_r & fifo_valid;
	assign fifo_ready = busy_r & rq_ready;
	assign accept     = rq_valid & rq_ready;

	assign rq_beat = '{data: fifo_data.data, last: beat_last, sop: (beat_cnt == '0)};
	assign rq_hdr  = '{addr: addr_r, dw_count: 11'(req_bytes >> 2)};

	assign done = accept & beat_last & final_req;
	assign busy = busy_r;

	always_ff @(posedge CLK) begin
		if (!eng_reset_n) begin
			busy_r   <= 1'b0;
			addr_r   <= '0;
			remain_r <= '0;
			beat_cnt <= '0;
		end else if (!busy_r) begin
			if (desc.start) begin
				busy_r   <= 1'b1;
				addr_r   <= desc.addr;
				remain_r <= desc.size & ~64'(`DMA_BEAT_BYTES - 1);
				beat_cnt <= '0;
			end
		end else if (accept) begin
			if (beat_last) begin   // Request complete, move to the next one
				beat_cnt <= '0;
				addr_r   <= addr_r + req_bytes;
				remain_r <= remain_r - req_bytes;
				if (final_req) busy_r <= 1'b0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dma_logic_sim

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module dma_logic_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
	exit 0
fi
exit 1

// File: tests/dma_logic_tb.sv
/* Testbench for the single-engine C2S write path.
   C2S gaps and rq_ready are random from one fixed seed, so every run is the same.
   Descriptor sizes are whole beats from 8 to 1024 bytes */
`timescale 1ns/1ps
`default_nettype none
`include "dma_consts.svh"

module dma_logic_tb;

	localparam int XFER_COUNT      = 20;
	localparam int MAX_XFER_BEATS  = 128;   // 1024 bytes of 8-byte beats
	localparam int WATCHDOG_CYCLES = (XFER_COUNT + 3) * MAX_XFER_BEATS * 8 + 2000;
	localparam logic [15:0] CTRL_A   = `DMA_ENGINE_BASE + `DMA_REG_CTRL;
	localparam logic [15:0] ADDR_A   = `DMA_ENGINE_BASE + `DMA_REG_ADDR;
	localparam logic [15:0] SIZE_A   = `DMA_ENGINE_BASE + `DMA_REG_SIZE;
	localparam logic [15:0] GLOBAL_A = `DMA_GLOBAL_REG;

	logic                  CLK = 1'b0;
	logic                  dma_reset_n = 1'b0;
	dma_pkg::reg_req_t     bus_req = '0;
	dma_pkg::reg_rsp_t     bus_rsp;
	logic                  c2s_valid = 1'b0;
	logic                  c2s_ready;
	dma_pkg::stream_beat_t c2s_data = '0;
	logic                  rq_valid;
	logic                  rq_ready = 1'b0;
	dma_pkg::stream_beat_t rq_beat;
	dma_pkg::rq_hdr_t      rq_hdr;
	logic                  irq;
	logic                  operation_in_course;

	// Reference model
	logic [63:0]           to_send [$];    // Beats not yet offered on C2S
	logic [63:0]           exp_data [$];
	dma_pkg::rq_hdr_t      exp_hdrs [$];
	dma_pkg::rq_hdr_t      cur_hdr;
	dma_pkg::stream_beat_t prev_beat;
	dma_pkg::rq_hdr_t      prev_hdr;
	integer                seed = 32'he270_7736;
	int                    beats_left = 0;
	int                    beat_total = 0;
	int                    fifo_fill = 0;   // Beats buffered between C2S and RQ
	bit                    fall_due = 1'b0;
	int                    stall_count = 0;
	bit                    stall_prev = 1'b0;
	bit                    c2s_hold = 1'b0;
	int                    errors = 0;
	int                    err_base = 0;
	int                    tests = 0;
	int                    passed = 0;

	dma_logic dma_logic_inst (
		.CLK                 (CLK),
		.dma_reset_n         (dma_reset_n),
		.bus_req             (bus_req),
		.bus_rsp             (bus_rsp),
		.c2s_valid           (c2s_valid),
		.c2s_ready           (c2s_ready),
		.c2s_data            (c2s_data),
		.rq_valid            (rq_valid),
		.rq_ready            (rq_ready),
		.rq_beat             (rq_beat),
		.rq_hdr              (rq_hdr),
		.irq                 (irq),
		.operation_in_course (operation_in_course)
	);

	always #5 CLK = ~CLK;

	task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		assert (ok) else begin
			$display("At %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_base) begin
			passed++;
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, errors - err_base);
		end
		err_base = errors;
	endtask

	////////////////////////////////////////
	// Register bus
	////////////////////////////////////////
	task automatic reg_access(input logic [15:0] addr, input logic [63:0] wdata,
		input logic [7:0] we, output logic [63:0] rdata);
		@(posedge CLK);
		bus_req <= '{en: 1'b1, addr: addr, wdata: wdata, we: we};
		@(posedge CLK);
		bus_req <= '0;
		check_eq("bus_rsp.ack", bus_rsp.ack, 0);   // Too early
		@(posedge CLK);
		check_eq("bus_rsp.ack", bus_rsp.ack, 1);
		rdata = bus_rsp.rdata;
	endtask

	task automatic reg_write(input logic [15:0] addr, input logic [63:0] wdata);
		logic [63:0] unused;
		reg_access(addr, wdata, 8'hff, unused);
	endtask

	task automatic reg_read(input logic [15:0] addr, output logic [63:0] rdata);
		reg_access(addr, '0, 8'h00, rdata);
	endtask

	// Queue the C2S beats and the expected requests of one descriptor
	task automatic load_model(input logic [63:0] addr, input int bytes);
		logic [63:0]      a;
		logic [63:0]      word;
		int               rem;
		int               len;
		dma_pkg::rq_hdr_t hdr;
		a = addr;
		rem = bytes;
		for (int i = 0; i < bytes / 8; i++) begin
			word = {$random(seed), $random(seed)};
			to_send.push_back(word);
			exp_data.push_back(word);
		end
		while (rem > 0) begin
			len = (rem > 128) ? 128 : rem;
			hdr.addr = a;
			hdr.dw_count = 11'(len / 4);
			exp_hdrs.push_back(hdr);
			a += 64'(len);
			rem -= len;
		end
	endtask

	task automatic start_engine(input logic [63:0] addr, input int bytes);
		reg_write(ADDR_A, addr);
		reg_write(SIZE_A, 64'(bytes));
		reg_write(CTRL_A, 64'h1);
		check_eq("operation_in_course", operation_in_course, 1);
	endtask

	task automatic run_transfer(input logic [63:0] addr, input int bytes, input bit irq_en);
		logic [63:0] rd;
		load_model(addr, bytes);
		start_engine(addr, bytes);
		while (operation_in_course === 1'b1) begin
			check_eq("irq", irq, 0);
			@(posedge CLK);
		end
		check_true(exp_hdrs.size() == 0 && exp_data.size() == 0 && beats_left == 0,
			"operation_in_course fell before all request beats were seen");
		check_eq("irq", irq, irq_en);   // Pending sets with the fall
		reg_read(CTRL_A, rd);
		check_eq("ctrl.stopped", rd[3], 1);
		check_eq("ctrl.pending", rd[7], 1);
		check_eq("irq", irq, irq_en);
		reg_write(CTRL_A, 64'h80);
		check_eq("irq", irq, 0);
		reg_read(CTRL_A, rd);
		check_eq("ctrl.pending", rd[7], 0);
	endtask

	function automatic int rand_size();
		return ((($random(seed) & 32'h7f) + 1) * 8);
	endfunction

	function automatic logic [63:0] rand_addr();
		return {$random(seed), $random(seed)} & ~64'h3;
	endfunction

	////////////////////////////////////////
	// Stimulus and monitor
	////////////////////////////////////////
	always @(posedge CLK) begin
		if (c2s_hold) begin
			c2s_valid <= 1'b0;
		end else if (!c2s_valid || c2s_ready) begin   // Slot free
			if (to_send.size() > 0 && ($random(seed) & 3) != 0) begin
				c2s_data  <= '{data: to_send[0], last: (to_send.size() == 1), sop: 1'b0};
				c2s_valid <= 1'b1;
				void'(to_send.pop_front());
			end else begin
				c2s_valid <= 1'b0;
			end
		end
	end

	always @(posedge CLK) rq_ready <= (($random(seed) & 3) != 0);

	always @(posedge CLK) begin
		if (dma_reset_n) begin
			if (fall_due) begin   // Final beat was taken one cycle ago
				check_eq("operation_in_course", operation_in_course, 0);
				fall_due = 1'b0;
			end
			if (!c2s_hold) begin
				check_eq("c2s_ready", c2s_ready, fifo_fill != `DMA_FIFO_DEPTH);
			end
			if (c2s_valid && c2s_ready) fifo_fill++;
			if (rq_valid && rq_ready) fifo_fill--;
			if (stall_prev && operation_in_course) begin   // Held beat must not move
				check_eq("rq_valid", rq_valid, 1);
				check_eq("rq_beat", rq_beat, prev_beat);
				check_eq("rq_hdr", rq_hdr, prev_hdr);
			end
			stall_prev = rq_valid && !rq_ready;
			prev_beat  = rq_beat;
			prev_hdr   = rq_hdr;
			if (stall_prev) stall_count++;
			if (rq_valid && rq_ready) begin
				if (beats_left == 0 && exp_hdrs.size() == 0) begin
					check_true(1'b0, "RQ beat accepted with no request expected");
				end else begin
					if (beats_left == 0) begin
						cur_hdr    = exp_hdrs.pop_front();
						beats_left = cur_hdr.dw_count / 2;
						check_eq("rq_beat.sop", rq_beat.sop, 1);
						check_eq("rq_hdr", rq_hdr, cur_hdr);
					end else begin
						check_eq("rq_beat.sop", rq_beat.sop, 0);
					end
					check_eq("rq_beat.data", rq_beat.data, exp_data.pop_front());
					beats_left--;
					check_eq("rq_beat.last", rq_beat.last, beats_left == 0);
					beat_total++;
					if (beats_left == 0 && exp_hdrs.size() == 0) fall_due = 1'b1;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, the run is stopped", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		logic [63:0] val;
		logic [63:0] rd;
		int          start_beats;
		repeat (2) @(posedge CLK);
		dma_reset_n <= 1'b1;

		// Register readback
		val = {$random(seed), $random(seed)};
		reg_write(ADDR_A, val);
		reg_read(ADDR_A, rd);
		check_eq("engine addr", rd, val);
		val = {$random(seed), $random(seed)};
		reg_write(SIZE_A, val);
		reg_read(SIZE_A, rd);
		check_eq("engine size", rd, val);
		reg_write(GLOBAL_A, 64'h40);
		reg_read(GLOBAL_A, rd);
		check_eq("global reg", rd, 64'h40);   // Payload code 0, irq enable set
		reg_read(16'h1000, rd);
		check_eq("unmapped read", rd, 0);
		end_test("register readback");

		for (int i = 0; i < XFER_COUNT; i++) begin
			run_transfer(rand_addr(), rand_size(), 1'b1);
		end
		end_test("random transfers and completion");

		check_true(stall_count > 0, "no back-pressure cycle was seen on RQ");
		end_test("back-pressure");

		reg_write(GLOBAL_A, 64'h0);
		run_transfer(rand_addr(), rand_size(), 1'b0);
		end_test("interrupt gating");

		// Soft reset in the middle of a long transfer
		reg_write(GLOBAL_A, 64'h40);
		start_beats = beat_total;
		val = rand_addr();
		load_model(val, 1024);
		start_engine(val, 1024);
		while (beat_total < start_beats + 4) @(posedge CLK);
		c2s_hold = 1'b1;
		reg_write(GLOBAL_A, 64'hc0);
		@(posedge CLK);
		check_eq("operation_in_course", operation_in_course, 0);
		to_send.delete();
		exp_data.delete();
		exp_hdrs.delete();
		beats_left = 0;
		fifo_fill = 0;
		reg_read(CTRL_A, rd);
		check_eq("engine ctrl", rd, 0);
		reg_read(ADDR_A, rd);
		check_eq("engine addr", rd, 0);
		reg_read(SIZE_A, rd);
		check_eq("engine size", rd, 0);
		reg_read(GLOBAL_A, rd);
		check_eq("global reg", rd, 64'h40);
		c2s_hold = 1'b0;
		run_transfer(rand_addr(), rand_size(), 1'b1);
		end_test("soft reset");

		$display("%0d tests, %0d passed, %0d failed, %0d errors, %0d RQ beats",
			tests, passed, tests - passed, errors, beat_total);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
